/* hw/i2c_bridge_pkg.sv */
package i2c_bridge_pkg;

  typedef enum logic [1:0] {
    TXN_WRITE2,
    TXN_READ4,
    TXN_FILTER
  } txn_kind_e;

  typedef enum logic [1:0] {
    OP_START,
    OP_WRITE,
    OP_READ,
    OP_STOP
  } byte_op_e;

  typedef enum logic [3:0] {
    SEQ_IDLE,
    SEQ_START,
    SEQ_ADDR_W,
    SEQ_WR0,
    SEQ_WR1,
    SEQ_WR2,
    SEQ_MID_STOP,
    SEQ_RESTART,
    SEQ_ADDR_R,
    SEQ_READ,
    SEQ_STOP
  } seq_state_e;

  // Command register map
  localparam logic [5:0] CMD_ADDR_BUS1   = 6'h3c;
  localparam logic [5:0] CMD_ADDR_BUS2   = 6'h3d;
  localparam logic [5:0] CMD_ADDR_FILTER = 6'h00;
  localparam logic [6:0] CMD_TAG         = 7'h03;

  // Command word fields
  localparam int CMD_TAG_LSB  = 25;
  localparam int CMD_RD_BIT   = 24;
  localparam int CMD_FILT_LSB = 17;
  localparam int CMD_DEV_LSB  = 16;
  localparam int CMD_D0_LSB   = 8;

  localparam logic [6:0] FILTER_DEV_ADDR = 7'h20;
  localparam logic [7:0] FILTER_REG      = 8'h0a;

  localparam int PRESCALE_W = 16;

endpackage

/* hw/i2c_txn_if.sv */
`timescale 1ns/1ps

interface i2c_txn_if;
  import i2c_bridge_pkg::*;

  logic       valid;
  txn_kind_e  kind;
  logic [6:0] dev_addr;
  logic [7:0] data0;
  logic [7:0] data1;
  logic       busy;

  modport decode (
    output valid,
    output kind,
    output dev_addr,
    output data0,
    output data1,
    input  busy
  );

  modport exec (
    input  valid,
    input  kind,
    input  dev_addr,
    input  data0,
    input  data1,
    output busy
  );

endinterface

/* hw/i2c_byte_if.sv */
`timescale 1ns/1ps

interface i2c_byte_if;
  import i2c_bridge_pkg::*;

  logic       go;
  byte_op_e   op;
  logic [7:0] wdata;
  logic       ack_out;
  logic       done;
  logic [7:0] rdata;
  logic       nack;

  modport seq (
    output go, op, wdata, ack_out,
    input  done, rdata, nack
  );

  modport eng (
    input  go, op, wdata, ack_out,
    output done, rdata, nack
  );

endinterface

/* hw/cmd_decode.sv */
`timescale 1ns/1ps

module cmd_decode (
  input  logic        clk,
  input  logic        rst,
  input  logic [5:0]  cmd_addr_i,
  input  logic [31:0] cmd_data_i,
  input  logic        cmd_rqst_i,
  i2c_txn_if.decode   txn,
  output logic        cmd_ack_o,
  output logic        ready_o,
  output logic        bus_sel_o
);
  import i2c_bridge_pkg::*;

  logic       is_xfer;
  logic       is_filter;
  logic       can_take;
  logic       take;
  logic       missed;
  logic [6:0] filt_code;
  logic [6:0] filt_q;
  logic       miss_q;
  logic       rd_wait_q;
  logic       busy_q;

  assign is_xfer = cmd_rqst_i
                && (cmd_addr_i == CMD_ADDR_BUS1 || cmd_addr_i == CMD_ADDR_BUS2)
                && cmd_data_i[CMD_TAG_LSB +: 7] == CMD_TAG;

  // Only a changed filter code costs a bus transfer
  assign filt_code = cmd_data_i[CMD_FILT_LSB +: 7];
  assign is_filter = cmd_rqst_i && cmd_addr_i == CMD_ADDR_FILTER && filt_code != filt_q;

  // A pending valid counts as busy until the sequencer picks it up
  assign can_take = !txn.busy && !txn.valid;
  assign take     = (is_xfer || is_filter) && can_take;
  assign missed   = (is_xfer || is_filter) && !can_take;

  assign ready_o   = !txn.busy;
  assign cmd_ack_o = !(miss_q || rd_wait_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      txn.valid <= 1'b0;
      filt_q    <= '0;
      bus_sel_o <= 1'b0;
      miss_q    <= 1'b0;
      rd_wait_q <= 1'b0;
      busy_q    <= 1'b0;
    end else begin
      txn.valid <= take;
      busy_q    <= txn.busy;
      if (take) begin
        bus_sel_o <= is_filter || cmd_addr_i == CMD_ADDR_BUS2;
        miss_q    <= 1'b0;
      end
      if (take && is_filter) filt_q <= filt_code;
      if (missed) miss_q <= 1'b1;
      if (take && is_xfer && cmd_data_i[CMD_RD_BIT]) begin
        rd_wait_q <= 1'b1;
      end else if (busy_q && !txn.busy) begin
        rd_wait_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      if (is_filter) begin
        txn.kind     <= TXN_FILTER;
        txn.dev_addr <= FILTER_DEV_ADDR;
        txn.data0    <= FILTER_REG;
        txn.data1    <= {1'b0, filt_code};
      end else begin
        txn.kind     <= cmd_data_i[CMD_RD_BIT] ? TXN_READ4 : TXN_WRITE2;
        txn.dev_addr <= cmd_data_i[CMD_DEV_LSB +: 7];
        txn.data0    <= cmd_data_i[CMD_D0_LSB +: 8];
        txn.data1    <= cmd_data_i[7:0];
      end
    end
  end

endmodule

/* hw/i2c_bit_engine.sv */
`timescale 1ns/1ps

module i2c_bit_engine #(
  parameter logic [i2c_bridge_pkg::PRESCALE_W-1:0] PRESCALE = 2
) (
  input  logic    clk,
  input  logic    rst,
  i2c_byte_if.eng bus,
  input  logic    scl_i,
  output logic    scl_o,
  output logic    scl_t_o,
  input  logic    sda_i,
  output logic    sda_o,
  output logic    sda_t_o
);
  import i2c_bridge_pkg::*;

  logic                  active;
  byte_op_e              op_q;
  logic [PRESCALE_W-1:0] pcnt;
  logic [1:0]            phase;
  logic [3:0]            bitcnt;
  logic [7:0]            shreg;
  logic                  ack_q;
  logic                  tick;
  logic                  ack_bit;
  logic                  last_phase;
  logic                  sample;
  logic                  bit_in;
  logic                  scl_n;
  logic                  sda_n;

  // Open drain, only the tristate controls move
  assign scl_o = 1'b0;
  assign sda_o = 1'b0;

  assign tick       = (pcnt == PRESCALE - 1'b1);
  assign ack_bit    = (bitcnt == 4'd8);
  assign last_phase = tick && phase == 2'd3
                   && (op_q == OP_START || op_q == OP_STOP || ack_bit);
  // Middle of SCL high
  assign sample     = tick && phase == 2'd2;
  // SCL not seen high reads as a released line
  assign bit_in     = sda_i || !scl_i;
  assign bus.rdata  = shreg;

  always_comb begin
    scl_n = 1'b1;
    sda_n = 1'b1;
    case (op_q)
      OP_START: begin
        // SDA falls while SCL is high, then SCL goes low
        scl_n = (phase != 2'd3);
        sda_n = (phase == 2'd0);
      end
      OP_STOP: begin
        scl_n = (phase != 2'd0);
        sda_n = phase[1];
      end
      default: begin
        scl_n = (phase == 2'd1) || (phase == 2'd2);
        if (op_q == OP_WRITE) sda_n = ack_bit ? 1'b1 : shreg[7];
        else sda_n = ack_bit ? ack_q : 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      active   <= 1'b0;
      op_q     <= OP_STOP;
      pcnt     <= '0;
      phase    <= 2'd0;
      bitcnt   <= 4'd0;
      bus.done <= 1'b0;
      bus.nack <= 1'b0;
      scl_t_o  <= 1'b1;
      sda_t_o  <= 1'b1;
    end else begin
      bus.done <= 1'b0;
      if (bus.go) begin
        active   <= 1'b1;
        op_q     <= bus.op;
        pcnt     <= '0;
        phase    <= 2'd0;
        bitcnt   <= 4'd0;
        bus.nack <= 1'b0;
      end else if (active) begin
        scl_t_o <= scl_n;
        sda_t_o <= sda_n;
        pcnt    <= tick ? '0 : pcnt + 1'b1;
        if (tick) begin
          phase <= phase + 2'd1;
          if (phase == 2'd3) bitcnt <= bitcnt + 4'd1;
        end
        if (last_phase) begin
          active   <= 1'b0;
          bus.done <= 1'b1;
        end
        if (sample && ack_bit && op_q == OP_WRITE) bus.nack <= bit_in;
      end
    end
  end

  // Write shifts after each bit period, read shifts in at the sample point
  always_ff @(posedge clk) begin
    if (bus.go) begin
      shreg <= bus.wdata;
      ack_q <= bus.ack_out;
    end else if (active && tick && !ack_bit) begin
      if (op_q == OP_WRITE && phase == 2'd3) begin
        shreg <= {shreg[6:0], 1'b0};
      end else if (op_q == OP_READ && sample) begin
        shreg <= {shreg[6:0], bit_in};
      end
    end
  end

endmodule

/* hw/i2c_sequencer.sv */
`timescale 1ns/1ps

module i2c_sequencer #(
  parameter logic [i2c_bridge_pkg::PRESCALE_W-1:0] PRESCALE = 2
) (
  input  logic       clk,
  input  logic       rst,
  i2c_txn_if.exec    txn,
  input  logic       scl_i,
  output logic       scl_o,
  output logic       scl_t_o,
  input  logic       sda_i,
  output logic       sda_o,
  output logic       sda_t_o,
  output logic       byte_stb_o,
  output logic [7:0] rbyte_o,
  output logic       byte_last_o
);
  import i2c_bridge_pkg::*;

  i2c_byte_if bus ();

  seq_state_e state;
  seq_state_e state_nxt;
  logic [1:0] rcnt;

  assign txn.busy    = (state != SEQ_IDLE);
  // NACK the fourth byte to end the read
  assign bus.ack_out = (rcnt == 2'd3);

  always_comb begin
    bus.op    = OP_WRITE;
    bus.wdata = 8'h00;
    case (state)
      SEQ_START, SEQ_RESTART: bus.op = OP_START;
      SEQ_ADDR_W:             bus.wdata = {txn.dev_addr, 1'b0};
      SEQ_ADDR_R:             bus.wdata = {txn.dev_addr, 1'b1};
      SEQ_WR0:                bus.wdata = txn.data0;
      SEQ_WR1:                bus.wdata = txn.data1;
      SEQ_READ:               bus.op = OP_READ;
      SEQ_WR2:                bus.op = OP_WRITE;
      default:                bus.op = OP_STOP;
    endcase
  end

  always_comb begin
    state_nxt = SEQ_IDLE;
    case (state)
      SEQ_START:    state_nxt = SEQ_ADDR_W;
      SEQ_ADDR_W:   state_nxt = bus.nack ? SEQ_STOP : SEQ_WR0;
      SEQ_WR0: begin
        if (bus.nack) state_nxt = SEQ_STOP;
        else if (txn.kind == TXN_READ4) state_nxt = SEQ_MID_STOP;
        else state_nxt = SEQ_WR1;
      end
      SEQ_WR1: begin
        if (!bus.nack && txn.kind == TXN_FILTER) state_nxt = SEQ_WR2;
        else state_nxt = SEQ_STOP;
      end
      SEQ_WR2:      state_nxt = SEQ_STOP;
      SEQ_MID_STOP: state_nxt = SEQ_RESTART;
      SEQ_RESTART:  state_nxt = SEQ_ADDR_R;
      SEQ_ADDR_R:   state_nxt = bus.nack ? SEQ_STOP : SEQ_READ;
      SEQ_READ:     state_nxt = (rcnt == 2'd3) ? SEQ_STOP : SEQ_READ;
      default:      state_nxt = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= SEQ_IDLE;
      bus.go      <= 1'b0;
      rcnt        <= 2'd0;
      byte_stb_o  <= 1'b0;
      byte_last_o <= 1'b0;
    end else begin
      bus.go      <= 1'b0;
      byte_stb_o  <= 1'b0;
      byte_last_o <= 1'b0;
      if (state == SEQ_IDLE) begin
        if (txn.valid) begin
          state  <= SEQ_START;
          bus.go <= 1'b1;
          rcnt   <= 2'd0;
        end
      end else if (bus.done) begin
        state  <= state_nxt;
        bus.go <= (state_nxt != SEQ_IDLE);
        if (state == SEQ_READ) begin
          byte_stb_o  <= 1'b1;
          byte_last_o <= (rcnt == 2'd3);
          rcnt        <= rcnt + 2'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.done && state == SEQ_READ) rbyte_o <= bus.rdata;
  end

  i2c_bit_engine #(
    .PRESCALE (PRESCALE)
  ) u_engine (
    .clk     (clk),
    .rst     (rst),
    .bus     (bus),
    .scl_i   (scl_i),
    .scl_o   (scl_o),
    .scl_t_o (scl_t_o),
    .sda_i   (sda_i),
    .sda_o   (sda_o),
    .sda_t_o (sda_t_o)
  );

endmodule

/* hw/read_collect.sv */
`timescale 1ns/1ps

module read_collect (
  input  logic        clk,
  input  logic        rst,
  input  logic        byte_stb_i,
  input  logic [7:0]  rbyte_i,
  input  logic        byte_last_i,
  output logic [31:0] resp_data_o,
  output logic        read_done_o
);

  logic [1:0]  idx;
  logic [31:0] stage;
  logic [31:0] merged;

  // Staging word with the incoming byte in its lane
  always_comb begin
    merged = stage;
    merged[{idx, 3'b000} +: 8] = rbyte_i;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      idx         <= 2'd0;
      resp_data_o <= '0;
      read_done_o <= 1'b0;
    end else begin
      read_done_o <= 1'b0;
      if (byte_stb_i) begin
        if (byte_last_i) begin
          idx         <= 2'd0;
          resp_data_o <= merged;
          read_done_o <= 1'b1;
        end else begin
          idx <= idx + 2'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_stb_i) stage <= merged;
  end

endmodule

/* hw/i2c_bridge_top.sv */
`timescale 1ns/1ps

module i2c_bridge_top #(
  parameter logic [i2c_bridge_pkg::PRESCALE_W-1:0] PRESCALE = 2
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [5:0]  cmd_addr_i,
  input  logic [31:0] cmd_data_i,
  input  logic        cmd_rqst_i,
  output logic        cmd_ack_o,
  output logic [31:0] cmd_resp_data_o,
  output logic        read_done_o,
  output logic        bus_sel_o,
  output logic        ready_o,
  input  logic        scl_i,
  output logic        scl_o,
  output logic        scl_t_o,
  input  logic        sda_i,
  output logic        sda_o,
  output logic        sda_t_o
);

  i2c_txn_if txn ();

  logic       byte_stb;
  logic [7:0] rbyte;
  logic       byte_last;

  cmd_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .cmd_addr_i (cmd_addr_i),
    .cmd_data_i (cmd_data_i),
    .cmd_rqst_i (cmd_rqst_i),
    .txn        (txn),
    .cmd_ack_o  (cmd_ack_o),
    .ready_o    (ready_o),
    .bus_sel_o  (bus_sel_o)
  );

  i2c_sequencer #(
    .PRESCALE (PRESCALE)
  ) u_seq (
    .clk         (clk),
    .rst         (rst),
    .txn         (txn),
    .scl_i       (scl_i),
    .scl_o       (scl_o),
    .scl_t_o     (scl_t_o),
    .sda_i       (sda_i),
    .sda_o       (sda_o),
    .sda_t_o     (sda_t_o),
    .byte_stb_o  (byte_stb),
    .rbyte_o     (rbyte),
    .byte_last_o (byte_last)
  );

  read_collect u_collect (
    .clk         (clk),
    .rst         (rst),
    .byte_stb_i  (byte_stb),
    .rbyte_i     (rbyte),
    .byte_last_i (byte_last),
    .resp_data_o (cmd_resp_data_o),
    .read_done_o (read_done_o)
  );

endmodule

/* testbench/i2c_target_model.sv */
`timescale 1ns/1ps

module i2c_target_model (
  input  logic        clk,
  input  logic        scl_i,
  input  logic        sda_i,
  input  logic [31:0] rd_word_i,
  output logic        sda_o
);

  // Every byte written by the master, with the device it went to
  logic [6:0] log_dev [0:255];
  logic [7:0] log_byte [0:255];
  logic [7:0] log_cnt = 8'd0;
  logic [7:0] stop_cnt = 8'd0;

  logic       scl_q = 1'b1;
  logic       sda_q = 1'b1;
  logic       drive = 1'b1;
  logic       active = 1'b0;
  logic       is_addr = 1'b0;
  logic       rd_mode = 1'b0;
  logic       m_nack = 1'b1;
  logic [3:0] bitcnt = 4'd0;
  logic [1:0] rd_idx = 2'd0;
  logic [7:0] shreg = 8'h00;
  logic [7:0] txbyte = 8'h00;
  logic [6:0] cur_dev = 7'h00;

  assign sda_o = drive;

  // Lines are oversampled on clk, SDA only moves one cycle after SCL falls
  always @(posedge clk) begin
    scl_q <= scl_i;
    sda_q <= sda_i;
    if (scl_q && scl_i && sda_q && !sda_i) begin
      active  <= 1'b1;
      is_addr <= 1'b1;
      rd_mode <= 1'b0;
      bitcnt  <= 4'd0;
      drive   <= 1'b1;
    end else if (scl_q && scl_i && !sda_q && sda_i) begin
      active   <= 1'b0;
      stop_cnt <= stop_cnt + 8'd1;
      drive    <= 1'b1;
    end else if (active && !scl_q && scl_i) begin
      if (bitcnt < 4'd8) shreg <= {shreg[6:0], sda_i};
      else m_nack <= sda_i;
      bitcnt <= bitcnt + 4'd1;
    end else if (active && scl_q && !scl_i) begin
      if (bitcnt == 4'd8) begin
        if (is_addr || !rd_mode) begin
          log_dev[log_cnt]  <= is_addr ? shreg[7:1] : cur_dev;
          log_byte[log_cnt] <= shreg;
          log_cnt           <= log_cnt + 8'd1;
          drive             <= 1'b0;
          if (is_addr) begin
            cur_dev <= shreg[7:1];
            rd_mode <= shreg[0];
            rd_idx  <= 2'd0;
          end
        end else begin
          // Master acknowledges its own read
          drive <= 1'b1;
        end
      end else if (bitcnt == 4'd9) begin
        bitcnt  <= 4'd0;
        is_addr <= 1'b0;
        if (rd_mode && (is_addr || !m_nack)) begin
          txbyte <= rd_word_i[{rd_idx, 3'b000} +: 8];
          drive  <= rd_word_i[{rd_idx, 3'b111}];
          rd_idx <= rd_idx + 2'd1;
        end else begin
          drive <= 1'b1;
        end
      end else if (rd_mode && !is_addr && bitcnt != 4'd0) begin
        drive <= txbyte[4'd7 - bitcnt];
      end
    end
  end

endmodule

/* testbench/tb_i2c_bridge.sv */
`timescale 1ns/1ps

module tb_i2c_bridge;
  import i2c_bridge_pkg::*;

  localparam logic [PRESCALE_W-1:0] PRESCALE = 2;
  localparam int MAX_TESTS  = 32;
  localparam int WAIT_LIMIT = 120 * 36 * PRESCALE;

  logic        clk;
  logic        rst;
  logic [5:0]  cmd_addr_i;
  logic [31:0] cmd_data_i;
  logic        cmd_rqst_i;
  logic        cmd_ack_o;
  logic [31:0] cmd_resp_data_o;
  logic        read_done_o;
  logic        bus_sel_o;
  logic        ready_o;
  logic        scl_o;
  logic        scl_t_o;
  logic        sda_o;
  logic        sda_t_o;
  logic        scl_line;
  logic        sda_line;
  logic        tgt_sda;
  logic [31:0] rd_word;

  // Eight words per test line
  logic [31:0] tests [0:8*MAX_TESTS-1];
  int          n_tests = 0;
  bit          tests_loaded = 1'b0;
  int          n_pass;
  int          n_fail;
  int          errors;
  logic        ack_expect;

  // Open-drain bus resolved as a wired AND of both sides
  assign scl_line = scl_t_o ? 1'b1 : scl_o;
  assign sda_line = (sda_t_o ? 1'b1 : sda_o) & tgt_sda;

  i2c_bridge_top #(
    .PRESCALE (PRESCALE)
  ) dut (
    .clk             (clk),
    .rst             (rst),
    .cmd_addr_i      (cmd_addr_i),
    .cmd_data_i      (cmd_data_i),
    .cmd_rqst_i      (cmd_rqst_i),
    .cmd_ack_o       (cmd_ack_o),
    .cmd_resp_data_o (cmd_resp_data_o),
    .read_done_o     (read_done_o),
    .bus_sel_o       (bus_sel_o),
    .ready_o         (ready_o),
    .scl_i           (scl_line),
    .scl_o           (scl_o),
    .scl_t_o         (scl_t_o),
    .sda_i           (sda_line),
    .sda_o           (sda_o),
    .sda_t_o         (sda_t_o)
  );

  i2c_target_model tgt (
    .clk       (clk),
    .scl_i     (scl_line),
    .sda_i     (sda_line),
    .rd_word_i (rd_word),
    .sda_o     (tgt_sda)
  );

  always #10 clk = ~clk;

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic wait_ready(input logic level, output bit ok);
    int n;
    n = 0;
    @(negedge clk);
    while (ready_o !== level && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    ok = (ready_o === level);
    if (!ok) begin
      $display("Timed out at %0t waiting for ready_o to become %b", $time, level);
      errors++;
    end
  endtask

  // Also collects cmd_ack_o on every cycle of the wait
  task automatic wait_read_done(output bit ok);
    int   n;
    logic ack_seen;
    n = 0;
    ack_seen = 1'b0;
    @(negedge clk);
    ack_seen = ack_seen | cmd_ack_o;
    while (read_done_o !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge clk);
      ack_seen = ack_seen | cmd_ack_o;
      n++;
    end
    ok = (read_done_o === 1'b1);
    if (!ok) begin
      $display("Timed out at %0t waiting for read_done_o", $time);
      errors++;
    end else begin
      check_bit("cmd_ack_o while read pending", ack_seen, 1'b0);
    end
  endtask

  task automatic send_cmd(input logic [5:0] addr, input logic [31:0] data);
    @(posedge clk);
    cmd_addr_i <= addr;
    cmd_data_i <= data;
    cmd_rqst_i <= 1'b1;
    @(posedge clk);
    cmd_rqst_i <= 1'b0;
  endtask

  task automatic run_test(input int t);
    logic [7:0]  row;
    logic [3:0]  kind;
    logic [5:0]  addr;
    logic [31:0] data;
    logic        busy_flag;
    logic [31:0] rd_exp;
    logic [31:0] exp_seq;
    logic [6:0]  exp_dev;
    logic [7:0]  n_exp;
    logic [7:0]  n_stops;
    logic [7:0]  base;
    logic [7:0]  stops;
    logic        idle_ready;
    int          err0;
    bit          ok;

    row       = 8'(t * 8);
    kind      = tests[row][3:0];
    addr      = tests[row + 8'd1][5:0];
    data      = tests[row + 8'd2];
    busy_flag = tests[row + 8'd3][0];
    rd_exp    = {tests[row + 8'd7][7:0], tests[row + 8'd6][7:0],
                 tests[row + 8'd5][7:0], tests[row + 8'd4][7:0]};
    err0      = errors;
    ok        = 1'b1;

    check_bit("cmd_ack_o before request", cmd_ack_o, ack_expect);
    check_bit("ready_o before request", ready_o, 1'b1);
    rd_word = rd_exp;
    base    = tgt.log_cnt;
    stops   = tgt.stop_cnt;

    exp_dev = data[22:16];
    exp_seq = 32'h0;
    n_exp   = 8'd0;
    n_stops = 8'd1;
    case (kind)
      4'd1: begin
        exp_seq = {data[22:16], 1'b0, data[15:8], data[7:0], 8'h00};
        n_exp   = 8'd3;
      end
      4'd2: begin
        exp_seq = {data[22:16], 1'b0, data[15:8], data[22:16], 1'b1, 8'h00};
        n_exp   = 8'd3;
        n_stops = 8'd2;
      end
      4'd3: begin
        exp_dev = FILTER_DEV_ADDR;
        exp_seq = {FILTER_DEV_ADDR, 1'b0, FILTER_REG, 1'b0, data[23:17], 8'h00};
        n_exp   = 8'd4;
      end
      default: n_stops = 8'd0;
    endcase

    repeat ($urandom % 6) @(posedge clk);
    send_cmd(addr, data);

    if (kind == 4'd0) begin
      idle_ready = 1'b1;
      repeat (8) begin
        @(negedge clk);
        idle_ready = idle_ready & ready_o;
      end
      check_bit("ready_o on ignored command", idle_ready, 1'b1);
    end else begin
      wait_ready(1'b0, ok);
      // Second request lands while the transfer is running
      if (ok && busy_flag) send_cmd(addr, data);
      if (ok && kind == 4'd2) begin
        wait_read_done(ok);
        if (ok) check_word("cmd_resp_data_o", cmd_resp_data_o, rd_exp);
      end
      if (ok) wait_ready(1'b1, ok);
      @(negedge clk);
      check_bit("bus_sel_o", bus_sel_o, kind == 4'd3 || addr == CMD_ADDR_BUS2);
      check_bit("cmd_ack_o after transfer", cmd_ack_o, !busy_flag);
      ack_expect = !busy_flag;
    end

    check_byte("logged byte count", tgt.log_cnt - base, n_exp);
    check_byte("stop count", tgt.stop_cnt - stops, n_stops);
    for (int j = 0; j < int'(n_exp); j++) begin
      check_byte("logged device", {1'b0, tgt.log_dev[base + 8'(j)]}, {1'b0, exp_dev});
      check_byte("logged byte", tgt.log_byte[base + 8'(j)], exp_seq[31:24]);
      exp_seq = exp_seq << 8;
    end

    if (errors == err0) n_pass++;
    else n_fail++;
    $display("case %0d kind %0d addr %h data %h: %s", t, kind, addr, data,
             (errors == err0) ? "ok" : "mismatch");
  endtask

  initial begin
    void'($urandom(32'h61491dc2));
    clk        = 1'b0;
    rst        = 1'b1;
    cmd_addr_i = 6'h00;
    cmd_data_i = 32'h0;
    cmd_rqst_i = 1'b0;
    rd_word    = 32'h0;
    n_pass     = 0;
    n_fail     = 0;
    errors     = 0;
    ack_expect = 1'b1;
    $readmemh("testbench/bridge_tests.txt", tests);
    while (n_tests < MAX_TESTS && tests[8'(n_tests * 8)] !== 32'hf) n_tests++;
    tests_loaded = 1'b1;

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_bit("cmd_ack_o after reset", cmd_ack_o, 1'b1);
    check_bit("ready_o after reset", ready_o, 1'b1);
    check_bit("read_done_o after reset", read_done_o, 1'b0);
    check_bit("bus_sel_o after reset", bus_sel_o, 1'b0);
    check_bit("scl_t_o after reset", scl_t_o, 1'b1);
    check_bit("sda_t_o after reset", sda_t_o, 1'b1);
    check_bit("scl_o after reset", scl_o, 1'b0);
    check_bit("sda_o after reset", sda_o, 1'b0);
    check_word("cmd_resp_data_o after reset", cmd_resp_data_o, 32'h0);
    $display("reset state: %s", (errors == 0) ? "ok" : "mismatch");

    for (int t = 0; t < n_tests; t++) run_test(t);

    $display("cases ok %0d, cases with errors %0d, errors %0d", n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    wait (tests_loaded);
    #(n_tests * 120 * 36 * PRESCALE * 20);
    $display("Watchdog expired at %0t before all cases finished", $time);
    $display("test failed");
    $finish;
  end

endmodule

/* testbench/bridge_tests.txt */
// kind cmd_addr cmd_data busy rd0 rd1 rd2 rd3 (rd0 is read first)
// kind: 0 ignored, 1 write, 2 read, 3 filter, f ends the list
1 3c 06501234 0 00 00 00 00
1 3d 0621a55a 0 00 00 00 00
2 3c 07480700 0 11 22 33 44
3 00 002a0000 0 00 00 00 00
0 00 002a0000 0 00 00 00 00
1 3c 0633dead 1 00 00 00 00
0 3c 08501234 0 00 00 00 00
0 10 06501234 0 00 00 00 00
1 3c 0634beef 0 00 00 00 00
2 3d 077faa00 0 a1 b2 c3 d4
3 00 00fe0000 0 00 00 00 00
0 00 00fe0000 0 00 00 00 00
1 3c 06000102 0 00 00 00 00
f 00 00000000 0 00 00 00 00

/* compile.f */
hw/i2c_bridge_pkg.sv
hw/i2c_txn_if.sv
hw/i2c_byte_if.sv
hw/cmd_decode.sv
hw/i2c_bit_engine.sv
hw/i2c_sequencer.sv
hw/read_collect.sv
hw/i2c_bridge_top.sv
testbench/i2c_target_model.sv
testbench/tb_i2c_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the I2C bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_i2c_bridge -o tb_i2c_bridge
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_i2c_bridge)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
